/* Bender.yml */
package:
  name: register_access_stall

sources:
  - logic/reg_stall_pkg.sv
  - logic/inst_fields_if.sv
  - logic/operand_source_decode.sv
  - logic/pending_write_table.sv
  - logic/stall_resolve.sv
  - logic/register_access_stall.sv
  - target: simulation
    files:
      - dv/register_access_stall_chk.sv
      - dv/reg_stall_scoreboard.sv
      - dv/tb_register_access_stall.sv

/* dv/reg_stall_scoreboard.sv */
// scoreboard for the register access stall detector
// shadow pending-write counters, a reference stall model and a per-cycle compare
`timescale 1ns/1ps

module reg_stall_scoreboard (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stack_op,
    input  reg_stall_pkg::size_t    register_size,
    input  reg_stall_pkg::op_type_t op0,
    input  reg_stall_pkg::reg_idx_t op0_reg,
    input  reg_stall_pkg::op_type_t op1,
    input  reg_stall_pkg::reg_idx_t op1_reg,
    input  reg_stall_pkg::modrm_t   mod_rm,
    input  reg_stall_pkg::sib_t     sib,
    input  reg_stall_pkg::reg_idx_t wb_reg,
    input  reg_stall_pkg::size_t    wb_size,
    input  logic                    wb_enable,
    input  logic                    next_stage_ready,
    input  logic                    is_stall,
    output int                      error_count
);

    // writes in flight per register as the DUT should hold them
    int shadow [reg_stall_pkg::NUM_REGS];

    // running totals
    int mismatches = 0;
    int checks     = 0;
    int test_start = 0;
    int tests_done = 0;

    assign error_count = mismatches;

    // does one operand read a register with a write in flight
    function automatic logic operand_busy(
        input reg_stall_pkg::op_type_t typ,
        input reg_stall_pkg::reg_idx_t oreg
    );
        logic [1:0]              md;
        reg_stall_pkg::reg_idx_t rm;
        logic                    busy;
        md   = mod_rm[7:6];
        rm   = mod_rm[2:0];
        busy = 1'b0;
        if ((typ == reg_stall_pkg::OP_REG) || (typ == reg_stall_pkg::OP_MEM)) begin
            busy = shadow[reg_stall_pkg::size_fold(oreg, register_size)] != 0;
        end else if (typ == reg_stall_pkg::OP_MODRM) begin
            if (md == 2'b11) begin
                busy = shadow[reg_stall_pkg::size_fold(rm, register_size)] != 0;
            end else if (rm == 3'b100) begin
                // sib base, plus the index unless it is 100
                busy = (shadow[sib[2:0]] != 0) || ((sib[5:3] != 3'b100) && (shadow[sib[5:3]] != 0));
            end else if (!((md == 2'b00) && (rm == 3'b101))) begin
                busy = shadow[rm] != 0;
            end
        end
        return busy;
    endfunction

    // stall expected from the current inputs and shadow counts
    function automatic logic expected_stall();
        return operand_busy(op0, op0_reg) || operand_busy(op1, op1_reg) ||
               (stack_op && (shadow[reg_stall_pkg::REG_ESP] != 0));
    endfunction

    // compare on the pre-edge values, then step the shadow counters
    always @(posedge clk) begin : track
        logic                    expected;
        logic                    writes;
        reg_stall_pkg::reg_idx_t dest;
        reg_stall_pkg::reg_idx_t wb_idx;
        if (!rst) begin
            expected = expected_stall();
            checks++;
            if (is_stall !== expected) begin
                $display("FAIL is_stall expected 0x%0h actual 0x%0h at %0t",
                         expected, is_stall, $time);
                mismatches++;
            end
        end
        // register operand or register-direct modrm is a destination
        writes = (op0 == reg_stall_pkg::OP_REG) ||
                 ((op0 == reg_stall_pkg::OP_MODRM) && (mod_rm[7:6] == 2'b11));
        dest   = reg_stall_pkg::size_fold((op0 == reg_stall_pkg::OP_REG) ? op0_reg : mod_rm[2:0],
                                          register_size);
        wb_idx = reg_stall_pkg::size_fold(wb_reg, wb_size);
        for (int i = 0; i < reg_stall_pkg::NUM_REGS; i++) begin
            if (rst) begin
                shadow[i] <= 0;
            end else begin
                shadow[i] <= shadow[i] + int'(writes && next_stage_ready && (dest == i))
                                       - int'(wb_enable && (wb_idx == i));
            end
        end
    end

    // one line per finished test
    task automatic end_test(input string name);
        int bad;
        bad = mismatches - test_start;
        tests_done++;
        if (bad == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, bad);
        end
        test_start = mismatches;
    endtask

    task automatic report_totals();
        $display("totals: %0d tests, %0d cycles compared, %0d mismatches",
                 tests_done, checks, mismatches);
    endtask

endmodule

/* dv/register_access_stall_chk.sv */
// assertion checks for the register access stall detector
// bound into the top level, watches stall and counter behavior
`timescale 1ns/1ps

module register_access_stall_chk #(
    parameter int COUNT_W = 4
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    stack_op,
    input logic                    is_stall,
    input logic [3:0]              src_valid,
    input logic [COUNT_W-1:0]      counts [reg_stall_pkg::NUM_REGS],
    input reg_stall_pkg::op_type_t op0,
    input reg_stall_pkg::reg_idx_t op0_reg,
    input reg_stall_pkg::size_t    register_size,
    input reg_stall_pkg::reg_idx_t wb_reg,
    input reg_stall_pkg::size_t    wb_size,
    input logic                    wb_enable,
    input logic                    next_stage_ready
);

    // register operand issue and writeback on the same register
    logic                    cancel;
    reg_stall_pkg::reg_idx_t dest;

    assign dest   = reg_stall_pkg::size_fold(op0_reg, register_size);
    assign cancel = next_stage_ready && (op0 == reg_stall_pkg::OP_REG) && wb_enable &&
                    (dest == reg_stall_pkg::size_fold(wb_reg, wb_size));

    a_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !is_stall)
        else $error("is_stall high in the first cycle after reset");

    a_no_source_no_stall: assert property (@(posedge clk) disable iff (rst)
        ((src_valid == 4'b0) && !stack_op) |-> !is_stall)
        else $error("is_stall high with no source read and no stack operation");

    a_cancel_holds: assert property (@(posedge clk) disable iff (rst)
        cancel |=> (counts[$past(dest)] == $past(counts[dest])))
        else $error("count changed although issue and writeback hit the same register");

endmodule

bind register_access_stall register_access_stall_chk #(.COUNT_W(COUNT_W)) u_chk (.*);

/* dv/tb_register_access_stall.sv */
// testbench for the register access stall detector
// directed hazard cases then a random mix, compared by the scoreboard
`timescale 1ns/1ps

module tb_register_access_stall;

    localparam int COUNT_W   = 4;
    localparam int COUNT_MAX = (1 << COUNT_W) - 1;

    logic                    clk;
    logic                    rst;
    logic                    stack_op;
    reg_stall_pkg::size_t    register_size;
    reg_stall_pkg::op_type_t op0;
    reg_stall_pkg::reg_idx_t op0_reg;
    reg_stall_pkg::op_type_t op1;
    reg_stall_pkg::reg_idx_t op1_reg;
    reg_stall_pkg::modrm_t   mod_rm;
    reg_stall_pkg::sib_t     sib;
    reg_stall_pkg::reg_idx_t wb_reg;
    reg_stall_pkg::size_t    wb_size;
    logic                    wb_enable;
    logic                    next_stage_ready;
    logic                    is_stall;
    int                      error_count;

    register_access_stall #(.COUNT_W(COUNT_W)) dut (.*);

    reg_stall_scoreboard sb (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_idle();
        stack_op         = 1'b0;
        register_size    = 2'd2;
        op0              = reg_stall_pkg::OP_NONE;
        op0_reg          = 3'd0;
        op1              = reg_stall_pkg::OP_NONE;
        op1_reg          = 3'd0;
        mod_rm           = 8'h00;
        sib              = 8'h00;
        wb_reg           = 3'd0;
        wb_size          = 2'd2;
        wb_enable        = 1'b0;
        next_stage_ready = 1'b1;
    endtask

    // one cycle with op0 as a register destination
    task automatic issue_write(input reg_stall_pkg::reg_idx_t dest,
                               input reg_stall_pkg::size_t size, input logic ready);
        op0              = reg_stall_pkg::OP_REG;
        op0_reg          = dest;
        register_size    = size;
        next_stage_ready = ready;
        next_cycle();
        op0              = reg_stall_pkg::OP_NONE;
        next_stage_ready = 1'b1;
    endtask

    // one-cycle writeback strobe
    task automatic write_back(input reg_stall_pkg::reg_idx_t r, input reg_stall_pkg::size_t size);
        wb_reg    = r;
        wb_size   = size;
        wb_enable = 1'b1;
        next_cycle();
        wb_enable = 1'b0;
    endtask

    // bounded wait for a stall level, sampled mid-cycle
    task automatic wait_stall(input logic level, input string what);
        int cycles;
        cycles = 0;
        #1;
        while ((is_stall !== level) && (cycles < 8)) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (is_stall !== level) begin
            $display("timeout waiting for is_stall to become %0b in %s", level, what);
            $display("TB FAILED");
            $finish;
        end
        next_cycle();
    endtask

    task automatic present_modrm(input reg_stall_pkg::modrm_t m, input reg_stall_pkg::sib_t s,
                                 input logic level, input string what);
        op1    = reg_stall_pkg::OP_MODRM;
        mod_rm = m;
        sib    = s;
        wait_stall(level, what);
    endtask

    // random fields, with issues and writebacks kept inside the counter range
    task automatic random_cycle();
        reg_stall_pkg::reg_idx_t dest;
        reg_stall_pkg::reg_idx_t wb_idx;
        logic                    writes;
        op0              = 3'($urandom_range(0, 6));
        op0_reg          = 3'($urandom_range(0, 7));
        op1              = 3'($urandom_range(0, 6));
        op1_reg          = 3'($urandom_range(0, 7));
        mod_rm           = 8'($urandom_range(0, 255));
        sib              = 8'($urandom_range(0, 255));
        register_size    = 2'($urandom_range(0, 3));
        stack_op         = ($urandom_range(0, 3) == 0);
        next_stage_ready = ($urandom_range(0, 3) != 0);
        writes = (op0 == reg_stall_pkg::OP_REG) ||
                 ((op0 == reg_stall_pkg::OP_MODRM) && (mod_rm[7:6] == 2'b11));
        dest   = reg_stall_pkg::size_fold((op0 == reg_stall_pkg::OP_REG) ? op0_reg : mod_rm[2:0],
                                          register_size);
        if (writes && (sb.shadow[dest] >= COUNT_MAX)) begin
            op0 = reg_stall_pkg::OP_IMM;
        end
        wb_reg    = 3'($urandom_range(0, 7));
        wb_size   = 2'($urandom_range(0, 3));
        wb_idx    = reg_stall_pkg::size_fold(wb_reg, wb_size);
        wb_enable = ($urandom_range(0, 1) == 1) && (sb.shadow[wb_idx] != 0);
        next_cycle();
    endtask

    initial begin
        void'($urandom(32'h8deb696b));
        rst = 1'b1;
        set_idle();
        // operands that would stall if any count survived reset
        op0      = reg_stall_pkg::OP_REG;
        op0_reg  = 3'd2;
        op1      = reg_stall_pkg::OP_REG;
        op1_reg  = 3'd2;
        stack_op = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        op0 = reg_stall_pkg::OP_NONE;
        wait_stall(1'b0, "reset");
        sb.end_test("reset");
        set_idle();

        // op1 reads ebx while its write is pending
        issue_write(3'd3, 2'd2, 1'b1);
        op1     = reg_stall_pkg::OP_REG;
        op1_reg = 3'd3;
        wait_stall(1'b1, "register hazard");
        next_cycle();
        write_back(3'd3, 2'd2);
        wait_stall(1'b0, "register writeback");
        // held by back-pressure so nothing becomes pending
        issue_write(3'd3, 2'd2, 1'b0);
        wait_stall(1'b0, "back-pressure");
        sb.end_test("register hazard");
        set_idle();

        // ebp pending, named through modrm and sib
        issue_write(3'd5, 2'd2, 1'b1);
        present_modrm(8'b01_000_101, 8'h00, 1'b1, "modrm base");
        present_modrm(8'b01_000_100, 8'b00_100_101, 1'b1, "sib base");
        present_modrm(8'b01_000_100, 8'b00_101_000, 1'b1, "sib index");
        // esp pending too, an index of 100 must not read it
        issue_write(reg_stall_pkg::REG_ESP, 2'd2, 1'b1);
        present_modrm(8'b01_000_100, 8'b00_100_000, 1'b0, "no sib index");
        present_modrm(8'b00_000_101, 8'h00, 1'b0, "disp32");
        write_back(3'd5, 2'd2);
        write_back(reg_stall_pkg::REG_ESP, 2'd2);
        sb.end_test("modrm and sib");
        set_idle();

        // ah write lands in eax
        issue_write(3'd4, reg_stall_pkg::SIZE_BYTE, 1'b1);
        register_size = 2'd2;
        op1           = reg_stall_pkg::OP_REG;
        op1_reg       = 3'd0;
        wait_stall(1'b1, "byte fold");
        write_back(3'd4, reg_stall_pkg::SIZE_BYTE);
        wait_stall(1'b0, "byte writeback");
        sb.end_test("byte folding");
        set_idle();

        issue_write(reg_stall_pkg::REG_ESP, 2'd2, 1'b1);
        stack_op = 1'b1;
        wait_stall(1'b1, "stack hazard");
        write_back(reg_stall_pkg::REG_ESP, 2'd2);
        wait_stall(1'b0, "stack writeback");
        issue_write(reg_stall_pkg::REG_ESP, 2'd2, 1'b1);
        // issue and writeback of esp in the same cycle
        op0       = reg_stall_pkg::OP_REG;
        op0_reg   = reg_stall_pkg::REG_ESP;
        wb_reg    = reg_stall_pkg::REG_ESP;
        wb_enable = 1'b1;
        next_cycle();
        op0       = reg_stall_pkg::OP_NONE;
        wb_enable = 1'b0;
        wait_stall(1'b1, "same-cycle cancel");
        write_back(reg_stall_pkg::REG_ESP, 2'd2);
        wait_stall(1'b0, "stack clear");
        sb.end_test("stack pointer");
        set_idle();

        repeat (2000) random_cycle();
        set_idle();
        next_cycle();
        sb.end_test("random mix");
        sb.report_totals();
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* logic/inst_fields_if.sv */
// instruction operand fields
// shared by the source decode and the pending-write table
`timescale 1ns/1ps

interface inst_fields_if;

    // operand descriptors
    reg_stall_pkg::op_type_t op0;
    reg_stall_pkg::reg_idx_t op0_reg;
    reg_stall_pkg::op_type_t op1;
    reg_stall_pkg::reg_idx_t op1_reg;

    // addressing bytes
    reg_stall_pkg::modrm_t mod_rm;
    reg_stall_pkg::sib_t   sib;

    // operand size of the instruction
    reg_stall_pkg::size_t register_size;

    // source decode needs every field
    modport decode (input op0, op0_reg, op1, op1_reg, mod_rm, sib, register_size);

    // table only looks at the op0 destination
    modport tbl (input op0, op0_reg, mod_rm, register_size);

endinterface

/* logic/operand_source_decode.sv */
// operand source decode
// finds up to four general-register reads from the op0 and op1 descriptors
`timescale 1ns/1ps

module operand_source_decode (
    inst_fields_if.decode           fields,
    output reg_stall_pkg::reg_idx_t src_reg [4],
    output logic [3:0]              src_valid
);

    // modrm and sib fields
    logic [1:0]              mod;
    reg_stall_pkg::reg_idx_t rm;
    reg_stall_pkg::reg_idx_t sib_base;
    reg_stall_pkg::reg_idx_t sib_index;

    // addressing mode flags
    logic mem_mode;
    logic uses_sib;
    logic disp32_only;
    logic sib_index_used;

    // register named by the modrm base path
    reg_stall_pkg::reg_idx_t modrm_r0;

    // first read of one operand, returns {valid, index}
    function automatic logic [3:0] first_read(
        input reg_stall_pkg::op_type_t typ,
        input reg_stall_pkg::reg_idx_t op_reg,
        input reg_stall_pkg::reg_idx_t modrm_reg,
        input logic                    modrm_reads,
        input reg_stall_pkg::size_t    size
    );
        logic                    valid;
        reg_stall_pkg::reg_idx_t idx;
        valid = 1'b0;
        idx   = reg_stall_pkg::size_fold(op_reg, size);
        case (typ)
            // direct register or register-held address
            reg_stall_pkg::OP_REG,
            reg_stall_pkg::OP_MEM: begin
                valid = 1'b1;
            end
            reg_stall_pkg::OP_MODRM: begin
                valid = modrm_reads;
                idx   = modrm_reg;
            end
            // no general register involved
            reg_stall_pkg::OP_NONE,
            reg_stall_pkg::OP_SEG,
            reg_stall_pkg::OP_MMX,
            reg_stall_pkg::OP_IMM: begin
                valid = 1'b0;
            end
            default: begin
                valid = 1'b0;
            end
        endcase
        return {valid, idx};
    endfunction

    assign mod       = fields.mod_rm[7:6];
    assign rm        = fields.mod_rm[2:0];
    assign sib_base  = fields.sib[2:0];
    assign sib_index = fields.sib[5:3];

    // mod 11 is register direct, anything else addresses memory
    assign mem_mode = (mod != 2'b11);
    // rm 100 in memory mode pulls in a sib byte
    assign uses_sib = mem_mode && (rm == 3'b100);
    // mod 00 rm 101 is a bare disp32, no base register
    assign disp32_only = (mod == 2'b00) && (rm == 3'b101);
    // sib index 100 means no index
    assign sib_index_used = uses_sib && (sib_index != 3'b100);

    // only the register-direct form is sized
    always_comb begin
        if (!mem_mode) begin
            modrm_r0 = reg_stall_pkg::size_fold(rm, fields.register_size);
        end else if (uses_sib) begin
            modrm_r0 = sib_base;
        end else begin
            modrm_r0 = rm;
        end
    end

    // op0 reads in slots 0 and 1, op1 in slots 2 and 3
    always_comb begin
        {src_valid[0], src_reg[0]} = first_read(fields.op0, fields.op0_reg, modrm_r0,
                                                !disp32_only, fields.register_size);
        {src_valid[2], src_reg[2]} = first_read(fields.op1, fields.op1_reg, modrm_r0,
                                                !disp32_only, fields.register_size);
        // second read is always the sib index
        src_valid[1] = (fields.op0 == reg_stall_pkg::OP_MODRM) && sib_index_used;
        src_reg[1]   = sib_index;
        src_valid[3] = (fields.op1 == reg_stall_pkg::OP_MODRM) && sib_index_used;
        src_reg[3]   = sib_index;
    end

endmodule

/* logic/pending_write_table.sv */
// pending write table
// one counter per general register of writes issued but not yet written back
`timescale 1ns/1ps

module pending_write_table #(
    parameter int COUNT_W = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    inst_fields_if.tbl              fields,
    input  reg_stall_pkg::reg_idx_t wb_reg,
    input  reg_stall_pkg::size_t    wb_size,
    input  logic                    wb_enable,
    input  logic                    next_stage_ready,
    output logic [COUNT_W-1:0]      counts [reg_stall_pkg::NUM_REGS]
);

    // modrm fields for the register-direct destination
    logic [1:0]              mod;
    reg_stall_pkg::reg_idx_t rm;

    // op0 destination
    logic                    dest_valid;
    reg_stall_pkg::reg_idx_t dest_reg;

    // folded writeback target
    reg_stall_pkg::reg_idx_t wb_idx;

    // destination actually moves on this cycle
    logic issue;

    assign mod = fields.mod_rm[7:6];
    assign rm  = fields.mod_rm[2:0];

    // op0 writes a register when it is a register or modrm with mod 11
    always_comb begin
        dest_valid = 1'b0;
        dest_reg   = reg_stall_pkg::size_fold(fields.op0_reg, fields.register_size);
        if (fields.op0 == reg_stall_pkg::OP_REG) begin
            dest_valid = 1'b1;
        end else if ((fields.op0 == reg_stall_pkg::OP_MODRM) && (mod == 2'b11)) begin
            dest_valid = 1'b1;
            dest_reg   = reg_stall_pkg::size_fold(rm, fields.register_size);
        end
    end

    // back-pressure holds the instruction, so nothing is added
    assign issue = dest_valid && next_stage_ready;

    // writebacks use the same byte fold as the destination
    assign wb_idx = reg_stall_pkg::size_fold(wb_reg, wb_size);

    for (genvar g = 0; g < reg_stall_pkg::NUM_REGS; g++) begin : g_cnt
        logic inc;
        logic dec;

        assign inc = issue && (dest_reg == reg_stall_pkg::reg_idx_t'(g));
        assign dec = wb_enable && (wb_idx == reg_stall_pkg::reg_idx_t'(g));

        // issue and writeback together cancel
        always_ff @(posedge clk) begin
            if (rst) begin
                counts[g] <= '0;
            end else begin
                case ({inc, dec})
                    2'b10: counts[g] <= counts[g] + 1'b1;
                    2'b01: counts[g] <= counts[g] - 1'b1;
                    default: counts[g] <= counts[g];
                endcase
            end
        end
    end

endmodule

/* logic/reg_stall_pkg.sv */
// register access stall definitions
// operand-type codes, decode field types and the byte-size register fold
package reg_stall_pkg;

    // general register index, eax through edi
    typedef logic [2:0] reg_idx_t;

    // operand type code from the instruction decoder
    typedef logic [2:0] op_type_t;

    // raw addressing bytes
    typedef logic [7:0] modrm_t;
    typedef logic [7:0] sib_t;

    // operand size code, 0 is byte
    typedef logic [1:0] size_t;

    // operand types
    localparam op_type_t OP_NONE  = 3'd0;
    localparam op_type_t OP_REG   = 3'd1;
    localparam op_type_t OP_SEG   = 3'd2;
    localparam op_type_t OP_MMX   = 3'd3;
    localparam op_type_t OP_MODRM = 3'd4;
    localparam op_type_t OP_IMM   = 3'd5;
    localparam op_type_t OP_MEM   = 3'd6;

    localparam size_t SIZE_BYTE = 2'd0;

    // stack pointer index
    localparam reg_idx_t REG_ESP = 3'd4;

    // one pending-write counter per general register
    localparam int NUM_REGS = 8;

    // byte operands name ah..bh as 4..7, which live in eax..ebx
    function automatic reg_idx_t size_fold(
        input reg_idx_t idx,
        input size_t    size
    );
        reg_idx_t folded;
        folded = idx;
        if ((size == SIZE_BYTE) && idx[2]) begin
            folded = idx - 3'd4;
        end
        return folded;
    endfunction

endpackage

/* logic/register_access_stall.sv */
// register access stall
// decode-stage hazard detector for reads of registers with writes pending
`timescale 1ns/1ps

module register_access_stall #(
    parameter int COUNT_W = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stack_op,
    input  reg_stall_pkg::size_t    register_size,
    input  reg_stall_pkg::op_type_t op0,
    input  reg_stall_pkg::reg_idx_t op0_reg,
    input  reg_stall_pkg::op_type_t op1,
    input  reg_stall_pkg::reg_idx_t op1_reg,
    input  reg_stall_pkg::modrm_t   mod_rm,
    input  reg_stall_pkg::sib_t     sib,
    input  reg_stall_pkg::reg_idx_t wb_reg,
    input  reg_stall_pkg::size_t    wb_size,
    input  logic                    wb_enable,
    input  logic                    next_stage_ready,
    output logic                    is_stall
);

    // instruction fields bundle
    inst_fields_if fields ();

    // source reads from the decode
    reg_stall_pkg::reg_idx_t src_reg [4];
    logic [3:0]              src_valid;

    // pending write counts
    logic [COUNT_W-1:0] counts [reg_stall_pkg::NUM_REGS];

    // current instruction fields
    assign fields.op0           = op0;
    assign fields.op0_reg       = op0_reg;
    assign fields.op1           = op1;
    assign fields.op1_reg       = op1_reg;
    assign fields.mod_rm        = mod_rm;
    assign fields.sib           = sib;
    assign fields.register_size = register_size;

    // which registers the instruction reads
    operand_source_decode u_decode (
        .fields    (fields.decode),
        .src_reg   (src_reg),
        .src_valid (src_valid)
    );

    // writes in flight per register
    pending_write_table #(
        .COUNT_W (COUNT_W)
    ) u_table (
        .clk              (clk),
        .rst              (rst),
        .fields           (fields.tbl),
        .wb_reg           (wb_reg),
        .wb_size          (wb_size),
        .wb_enable        (wb_enable),
        .next_stage_ready (next_stage_ready),
        .counts           (counts)
    );

    // combine reads, counts and the stack check
    stall_resolve #(
        .COUNT_W (COUNT_W)
    ) u_resolve (
        .src_reg   (src_reg),
        .src_valid (src_valid),
        .counts    (counts),
        .stack_op  (stack_op),
        .is_stall  (is_stall)
    );

endmodule

/* logic/stall_resolve.sv */
// stall resolve
// checks each valid source and the stack pointer against the pending counts
`timescale 1ns/1ps

module stall_resolve #(
    parameter int COUNT_W = 4
) (
    input  reg_stall_pkg::reg_idx_t src_reg [4],
    input  logic [3:0]              src_valid,
    input  logic [COUNT_W-1:0]      counts [reg_stall_pkg::NUM_REGS],
    input  logic                    stack_op,
    output logic                    is_stall
);

    // count seen by each source slot
    logic [COUNT_W-1:0] src_count [4];

    // per-slot hazard
    logic [3:0] src_busy;

    // stack pointer still has a write in flight
    logic esp_busy;
    logic stack_hit;

    // look up each source index in the table
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            src_count[j] = counts[src_reg[j]];
        end
    end

    // a slot only matters when the decode says it is read
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            src_busy[j] = src_valid[j] && (src_count[j] != '0);
        end
    end

    // push and pop use esp implicitly
    assign esp_busy  = (counts[reg_stall_pkg::REG_ESP] != '0);
    assign stack_hit = stack_op && esp_busy;

    // any hazard holds the decode stage
    assign is_stall = (|src_busy) || stack_hit;

endmodule

/* register_access_stall.f */
logic/reg_stall_pkg.sv
logic/inst_fields_if.sv
logic/operand_source_decode.sv
logic/pending_write_table.sv
logic/stall_resolve.sv
logic/register_access_stall.sv
dv/register_access_stall_chk.sv
dv/reg_stall_scoreboard.sv
dv/tb_register_access_stall.sv
